//--- ntm_tensor_pkg.sv
//////////////////////////////////////////////////////////////////////
// Tensor transpose data and geometry types
// Element defaults, per-axis index, tensor dimensions and positions
//////////////////////////////////////////////////////////////////////

package ntm_tensor_pkg;

  //////////////////////////////////////////////////////////////////////
  // Element and buffer defaults
  //////////////////////////////////////////////////////////////////////

  // Element width picked up by the top level
  localparam int DATA_SIZE_DEFAULT = 16;
  // Buffer address width, 4096 entries covers 15*15*15
  localparam int ADDR_SIZE_DEFAULT = 12;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////

  // One axis index, sizes 1 to 15
  localparam int INDEX_SIZE = 4;

  typedef logic [INDEX_SIZE-1:0] index_t;

  // Run-time sizes, size_k is the fastest axis on input
  typedef struct packed {
    index_t size_i;
    index_t size_j;
    index_t size_k;
  } tensor_dims_t;

  // Position along three generic axes
  // pos_c runs fastest, pos_a slowest
  typedef struct packed {
    index_t pos_a;
    index_t pos_b;
    index_t pos_c;
  } tensor_pos_t;

endpackage

//--- ntm_transpose_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Tensor transpose control types
// Element strobe group and phase FSM encoding
//////////////////////////////////////////////////////////////////////

package ntm_transpose_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Strobes
  //////////////////////////////////////////////////////////////////////

  // Same layout on input and output streams
  typedef struct packed {
    // First element of a matrix
    logic i_enable;
    // First element of a row
    logic j_enable;
    // Valid element
    logic k_enable;
  } tensor_strobe_t;

  //////////////////////////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // Idle, waiting for START
    starter_state = 2'd0,
    // Taking input elements into the buffer
    load_state    = 2'd1,
    // Reading back in swapped axis order
    drain_state   = 2'd2,
    // Last read issued, READY follows
    finish_state  = 2'd3
  } transpose_state_t;

endpackage

//--- tensor_index_counter.sv
//////////////////////////////////////////////////////////////////////
// Tensor index counter
// Nested three-axis position counter with boundary strobes,
// final position flag and realignment from incoming strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tensor_index_counter
  import ntm_tensor_pkg::*;
  import ntm_transpose_ctrl_pkg::*;
(
  input  logic           CLK,
  input  logic           RST,
  input  logic           clear,
  input  logic           step,
  input  tensor_dims_t   dims,
  input  tensor_strobe_t realign,
  output tensor_pos_t    pos,
  output tensor_strobe_t first,
  output logic           last
);

  // Stored position, next position to be used
  tensor_pos_t pos_q;
  tensor_pos_t nxt;
  logic        end_a;
  logic        end_b;
  logic        end_c;

  // Current position after realignment
  // Matrix start drops row and column, row start drops column
  always_comb begin
    pos = pos_q;
    if (step && realign.i_enable) begin
      pos.pos_b = '0;
      pos.pos_c = '0;
    end else if (step && realign.j_enable) begin
      pos.pos_c = '0;
    end
  end

  // Axis boundaries, dims permuted by the caller
  assign end_a = (pos.pos_a == dims.size_i - index_t'(1));
  assign end_b = (pos.pos_b == dims.size_j - index_t'(1));
  assign end_c = (pos.pos_c == dims.size_k - index_t'(1));
  assign last  = end_a && end_b && end_c;

  // Boundary strobes for the element at pos
  assign first.k_enable = step;
  assign first.j_enable = step && (pos.pos_c == '0);
  assign first.i_enable = step && (pos.pos_c == '0) && (pos.pos_b == '0);

  // Carry chain c -> b -> a, full wrap back to origin
  always_comb begin
    nxt = pos;
    if (!end_c) begin
      nxt.pos_c = pos.pos_c + index_t'(1);
    end else begin
      nxt.pos_c = '0;
      if (!end_b) begin
        nxt.pos_b = pos.pos_b + index_t'(1);
      end else begin
        nxt.pos_b = '0;
        nxt.pos_a = end_a ? '0 : pos.pos_a + index_t'(1);
      end
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pos_q <= '0;
    end else if (clear) begin
      pos_q <= '0;
    end else if (step) begin
      pos_q <= nxt;
    end
  end

endmodule

//--- tensor_buffer.sv
//////////////////////////////////////////////////////////////////////
// Tensor element buffer
// One write port, one read port with registered read data
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tensor_buffer
  import ntm_tensor_pkg::*;
#(
  parameter int DATA_SIZE = DATA_SIZE_DEFAULT,
  parameter int ADDR_SIZE = ADDR_SIZE_DEFAULT
)
(
  input  logic                 CLK,
  input  logic                 wr_en,
  input  logic [ADDR_SIZE-1:0] wr_addr,
  input  logic [DATA_SIZE-1:0] wr_data,
  input  logic                 rd_en,
  input  logic [ADDR_SIZE-1:0] rd_addr,
  output logic [DATA_SIZE-1:0] rd_data
);

  localparam int DEPTH = 2 ** ADDR_SIZE;

  // Element storage, one word per tensor element
  logic [DATA_SIZE-1:0] mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Data valid the cycle after rd_en
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- ntm_tensor_transpose.sv
//////////////////////////////////////////////////////////////////////
// Tensor transpose controller
// Latches sizes, loads the tensor into the buffer in (i, j, k) order,
// drains it in (k, j, i) order with i fastest, then pulses READY
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_tensor_transpose
  import ntm_tensor_pkg::*;
  import ntm_transpose_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = DATA_SIZE_DEFAULT,
  parameter int ADDR_SIZE = ADDR_SIZE_DEFAULT
)
(
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  input  tensor_dims_t         SIZE_IN,
  output logic                 READY,

  // Input stream
  input  tensor_strobe_t       DATA_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] DATA_IN,

  // Output stream
  output tensor_strobe_t       DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] DATA_OUT,

  // Buffer write side
  output logic                 wr_en,
  output logic [ADDR_SIZE-1:0] wr_addr,
  output logic [DATA_SIZE-1:0] wr_data,

  // Buffer read side
  output logic                 rd_en,
  output logic [ADDR_SIZE-1:0] rd_addr,
  input  logic [DATA_SIZE-1:0] rd_data
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  transpose_state_t state;

  // Sizes latched on START
  tensor_dims_t dims_q;
  // Sizes as seen by the drain counter, (K, J, I)
  tensor_dims_t out_dims;

  // Counter control
  logic clear_cnt;
  logic in_step;
  logic in_last;
  logic out_step;
  logic out_last;

  // Counter positions and drain boundary strobes
  tensor_pos_t    in_pos;
  tensor_pos_t    out_pos;
  tensor_strobe_t out_first;

  //////////////////////////////////////////////////////////////////////
  // Address arithmetic
  //////////////////////////////////////////////////////////////////////

  // Row-major linear address (a * size_b + b) * size_c + c
  function automatic logic [ADDR_SIZE-1:0] linear_addr(
    input index_t a,
    input index_t b,
    input index_t c,
    input index_t size_b,
    input index_t size_c
  );
    logic [ADDR_SIZE-1:0] row;
    row = ADDR_SIZE'(a) * ADDR_SIZE'(size_b) + ADDR_SIZE'(b);
    return row * ADDR_SIZE'(size_c) + ADDR_SIZE'(c);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  // Both counters restart on an accepted START
  assign clear_cnt = (state == starter_state) && START;

  // Input strobes only count during load
  assign in_step = (state == load_state) && DATA_IN_ENABLE.k_enable;

  // One read per drain cycle, no gaps
  assign out_step = (state == drain_state);

  // Axes swapped, i becomes the fastest axis
  always_comb begin
    out_dims.size_i = dims_q.size_k;
    out_dims.size_j = dims_q.size_j;
    out_dims.size_k = dims_q.size_i;
  end

  // Load order i, j, k with realignment from the source strobes
  tensor_index_counter u_in_counter (
    .CLK     (CLK),
    .RST     (RST),
    .clear   (clear_cnt),
    .step    (in_step),
    .dims    (dims_q),
    .realign (DATA_IN_ENABLE),
    .pos     (in_pos),
    .first   (),
    .last    (in_last)
  );

  // Drain order k, j, i, self-timed so no realignment
  tensor_index_counter u_out_counter (
    .CLK     (CLK),
    .RST     (RST),
    .clear   (clear_cnt),
    .step    (out_step),
    .dims    (out_dims),
    .realign ('0),
    .pos     (out_pos),
    .first   (out_first),
    .last    (out_last)
  );

  //////////////////////////////////////////////////////////////////////
  // Buffer access
  //////////////////////////////////////////////////////////////////////

  // Element (i, j, k) lands at i*J*K + j*K + k
  assign wr_en   = in_step;
  assign wr_data = DATA_IN;
  assign wr_addr = linear_addr(in_pos.pos_a, in_pos.pos_b, in_pos.pos_c,
                               dims_q.size_j, dims_q.size_k);

  // Drain position is (k, j, i), same linear mapping as the load
  assign rd_en   = out_step;
  assign rd_addr = linear_addr(out_pos.pos_c, out_pos.pos_b, out_pos.pos_a,
                               dims_q.size_j, dims_q.size_k);

  //////////////////////////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= starter_state;
      dims_q <= '0;
    end else begin
      case (state)
        starter_state: begin
          // START ignored in every other state
          if (START) begin
            dims_q <= SIZE_IN;
            state  <= load_state;
          end
        end
        load_state: begin
          // Drain begins right after the final write
          if (in_step && in_last) begin
            state <= drain_state;
          end
        end
        drain_state: begin
          if (out_last) begin
            state <= finish_state;
          end
        end
        finish_state: begin
          state <= starter_state;
        end
        default: begin
          state <= starter_state;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////////////////////////

  // Strobes delayed one cycle to meet the registered read
  // READY lands one cycle after the last output element
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT_ENABLE <= '0;
      READY           <= 1'b0;
    end else begin
      DATA_OUT_ENABLE <= out_first;
      READY           <= (state == finish_state);
    end
  end

  // Zero between elements, buffer data while valid
  assign DATA_OUT = DATA_OUT_ENABLE.k_enable ? rd_data : '0;

endmodule

//--- ntm_transpose_top.sv
//////////////////////////////////////////////////////////////////////
// Tensor transpose top level
// Controller plus element buffer, swaps the i and k axes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_transpose_top
  import ntm_tensor_pkg::*;
  import ntm_transpose_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = DATA_SIZE_DEFAULT,
  parameter int ADDR_SIZE = ADDR_SIZE_DEFAULT
)
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  tensor_dims_t         SIZE_IN,
  input  tensor_strobe_t       DATA_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] DATA_IN,
  output tensor_strobe_t       DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 READY
);

  // Buffer port wiring
  logic                 wr_en;
  logic [ADDR_SIZE-1:0] wr_addr;
  logic [DATA_SIZE-1:0] wr_data;
  logic                 rd_en;
  logic [ADDR_SIZE-1:0] rd_addr;
  logic [DATA_SIZE-1:0] rd_data;

  // Phase control and address generation
  ntm_tensor_transpose #(
    .DATA_SIZE (DATA_SIZE),
    .ADDR_SIZE (ADDR_SIZE)
  ) u_ntm_tensor_transpose (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .READY           (READY),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // Holds one whole tensor
  tensor_buffer #(
    .DATA_SIZE (DATA_SIZE),
    .ADDR_SIZE (ADDR_SIZE)
  ) u_tensor_buffer (
    .CLK     (CLK),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- tb_ntm_transpose.sv
//////////////////////////////////////////////////////////////////////
// Tensor transpose testbench
// Random tensors from an LCG, a reference transpose model and
// cycle-exact checks of the output stream, its strobes and READY
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ntm_transpose
  import ntm_tensor_pkg::*;
  import ntm_transpose_ctrl_pkg::*;
();

  localparam int DATA_SIZE = DATA_SIZE_DEFAULT;
  localparam int ADDR_SIZE = ADDR_SIZE_DEFAULT;
  // Three edge shapes plus twenty random tensors
  localparam int NUM_TESTS = 23;
  localparam int MAX_ELEMS = 3375;

  typedef logic [DATA_SIZE-1:0] data_t;

  // DUT ports
  logic           CLK = 1'b0;
  logic           RST;
  logic           START;
  tensor_dims_t   SIZE_IN;
  tensor_strobe_t DATA_IN_ENABLE;
  data_t          DATA_IN;
  tensor_strobe_t DATA_OUT_ENABLE;
  data_t          DATA_OUT;
  logic           READY;

  // Run bookkeeping
  int unsigned lcg_state   = 79;
  int          cyc         = 0;
  int          cycle_limit = 0;
  bit          started     = 1'b0;

  // Expected drain window, parked far away until a tensor is loaded
  int drain_start = 1 << 30;
  int drain_len   = 0;

  // Model storage, input tensor row-major in (i, j, k)
  data_t          tensor_mem [MAX_ELEMS];
  data_t          exp_data [$];
  tensor_strobe_t exp_strobe [$];

  // Test list
  tensor_dims_t test_dims [NUM_TESTS];
  int           test_gap [NUM_TESTS];
  bit           test_stray [NUM_TESTS];

  ntm_transpose_top #(
    .DATA_SIZE (DATA_SIZE),
    .ADDR_SIZE (ADDR_SIZE)
  ) u_ntm_transpose_top (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_IN         (SIZE_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .READY           (READY)
  );

  // 8 ns clock
  always #4 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // 32-bit LCG, low bits dropped since they cycle quickly
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  // Mostly 1 to 4, now and then anything up to 15
  function automatic index_t pick_size();
    if (lcg_next() % 4 != 0) begin
      return index_t'(1 + lcg_next() % 4);
    end
    return index_t'(1 + lcg_next() % 15);
  endfunction

  task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "Transpose testbench stopped");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_strobe(input string name, input tensor_strobe_t got,
                              input tensor_strobe_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // One tensor: model, load, optional stray input, wait for READY
  //////////////////////////////////////////////////////////////////////

  task automatic run_tensor(input tensor_dims_t dims, input int max_gap, input bit stray);
    int ni;
    int nj;
    int nk;
    int n;
    int i;
    int j;
    int k;
    tensor_strobe_t s;
    ni = int'(dims.size_i);
    nj = int'(dims.size_j);
    nk = int'(dims.size_k);
    n  = ni * nj * nk;
    for (i = 0; i < n; i++) begin
      tensor_mem[i] = data_t'(lcg_next());
    end
    // Output position (k, j, i) carries in(i, j, k), i fastest
    exp_data.delete();
    exp_strobe.delete();
    for (k = 0; k < nk; k++) begin
      for (j = 0; j < nj; j++) begin
        for (i = 0; i < ni; i++) begin
          s.k_enable = 1'b1;
          s.j_enable = (i == 0);
          s.i_enable = (i == 0) && (j == 0);
          exp_data.push_back(tensor_mem[i * nj * nk + j * nk + k]);
          exp_strobe.push_back(s);
        end
      end
    end
    // Size latch
    next_cycle();
    START   = 1'b1;
    SIZE_IN = dims;
    started = 1'b1;
    next_cycle();
    START = 1'b0;
    // Load in (i, j, k) order
    for (i = 0; i < ni; i++) begin
      for (j = 0; j < nj; j++) begin
        for (k = 0; k < nk; k++) begin
          if (max_gap > 0) begin
            repeat (int'(lcg_next() % (max_gap + 1))) begin
              DATA_IN_ENABLE = '0;
              DATA_IN        = data_t'(lcg_next());
              next_cycle();
            end
          end
          DATA_IN_ENABLE.k_enable = 1'b1;
          DATA_IN_ENABLE.j_enable = (k == 0);
          DATA_IN_ENABLE.i_enable = (j == 0) && (k == 0);
          DATA_IN = tensor_mem[i * nj * nk + j * nk + k];
          // First output due two cycles after the last strobe
          if (i == ni - 1 && j == nj - 1 && k == nk - 1) begin
            drain_len   = n;
            drain_start = cyc + 2;
          end
          next_cycle();
        end
      end
    end
    DATA_IN_ENABLE = '0;
    // Junk strobes and START pulses, stopping before the idle state
    if (stray) begin
      while (cyc <= drain_start + n - 2) begin
        DATA_IN_ENABLE = tensor_strobe_t'(3'(lcg_next()));
        DATA_IN        = data_t'(lcg_next());
        START          = (lcg_next() % 2 == 1);
        SIZE_IN        = tensor_dims_t'(12'(lcg_next()));
        next_cycle();
      end
      DATA_IN_ENABLE = '0;
      START          = 1'b0;
    end
    while (READY !== 1'b1) begin
      @(negedge CLK);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor and watchdog
  //////////////////////////////////////////////////////////////////////

  // Outputs sampled mid-cycle
  always @(negedge CLK) begin : output_monitor
    int idx;
    if (!RST) begin
      if (cyc >= drain_start && cyc < drain_start + drain_len) begin
        idx = cyc - drain_start;
        check_strobe("DATA_OUT_ENABLE", DATA_OUT_ENABLE, exp_strobe[idx]);
        check_data("DATA_OUT", DATA_OUT, exp_data[idx]);
      end else begin
        check_strobe("DATA_OUT_ENABLE", DATA_OUT_ENABLE, '0);
        if (!started) begin
          check_data("DATA_OUT", DATA_OUT, '0);
        end
      end
      // Single pulse right after the last element
      check_ready("READY", READY, cyc == drain_start + drain_len);
    end
  end

  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      $display("Timeout: transpose run did not finish within %0d cycles", cycle_limit);
      stop_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int t;
    int n;
    int budget;
    RST            = 1'b1;
    START          = 1'b0;
    SIZE_IN        = '0;
    DATA_IN_ENABLE = '0;
    DATA_IN        = '0;
    // Edge shapes first
    test_dims[0]  = {index_t'(1), index_t'(1), index_t'(1)};
    test_gap[0]   = 0;
    test_stray[0] = 1'b0;
    test_dims[1]  = {index_t'(1), index_t'(9), index_t'(1)};
    test_gap[1]   = 1;
    test_stray[1] = 1'b1;
    test_dims[2]  = {index_t'(15), index_t'(1), index_t'(15)};
    test_gap[2]   = 3;
    test_stray[2] = 1'b1;
    for (t = 3; t < NUM_TESTS; t++) begin
      test_dims[t]  = {pick_size(), pick_size(), pick_size()};
      test_gap[t]   = int'(lcg_next() % 4);
      test_stray[t] = (t % 2 == 1);
    end
    // Load, worst-case gaps, drain and overhead per test, doubled
    budget = 0;
    for (t = 0; t < NUM_TESTS; t++) begin
      n = int'(test_dims[t].size_i) * int'(test_dims[t].size_j) *
          int'(test_dims[t].size_k);
      budget += 2 * n + test_gap[t] * n + 10;
    end
    cycle_limit = 2 * budget + 20;

    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;
    // Strobes before any START must be ignored
    repeat (4) begin
      DATA_IN_ENABLE = tensor_strobe_t'(3'(lcg_next()));
      DATA_IN        = data_t'(lcg_next());
      next_cycle();
    end
    DATA_IN_ENABLE = '0;

    for (t = 0; t < NUM_TESTS; t++) begin
      run_tensor(test_dims[t], test_gap[t], test_stray[t]);
    end
    repeat (3) next_cycle();

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- tb.f
ntm_tensor_pkg.sv
ntm_transpose_ctrl_pkg.sv
tensor_index_counter.sv
tensor_buffer.sv
ntm_tensor_transpose.sv
ntm_transpose_top.sv
tb_ntm_transpose.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the tensor transpose testbench with Verilator.
# A failing check ends the simulation with $fatal, so the exit
# status of the simulator carries pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_ntm_transpose \
  -f tb.f \
  -o sim_tb_ntm_transpose

./obj_dir/sim_tb_ntm_transpose
